// ==== Makefile ====
TOP := tb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== flist.f ====
+incdir+hw
hw/plic_pkg.sv
hw/plic_regs.sv
hw/plic_gateway.sv
hw/plic_target.sv
hw/plic_top.sv
tb/tb_clk_gen.sv
tb/tb_checker.sv
tb/tb_top.sv

// ==== hw/plic_config.svh ====
`ifndef PLIC_CONFIG_SVH
`define PLIC_CONFIG_SVH

// Source slots, slot 0 is reserved.
`define PLIC_SRC_NUM 8
`define PLIC_CTX_NUM 2

`define PLIC_PRIO_W  3
`define PLIC_ADDR_W  12
`define PLIC_DATA_W  32

//////////////////////////////
// Register map.
//////////////////////////////
`define PLIC_OFS_PRIO  12'h000 // + 4 * source.
`define PLIC_OFS_PEND  12'h080
`define PLIC_OFS_TYPE  12'h084 // 1 is level.
`define PLIC_OFS_EN    12'h100 // + 4 * context.
`define PLIC_OFS_TH    12'h200 // + 8 * context.
`define PLIC_OFS_CLAIM 12'h204 // + 8 * context.

`endif

// ==== hw/plic_gateway.sv ====
`include "plic_config.svh"

module plic_gateway #(
    parameter int SRC_ID = 1
) (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic                                   src_i,
    input  logic                                   type_i, // 1 is level.
    input  plic_pkg::src_id_t [`PLIC_CTX_NUM-1:0]  claim_id_i,
    input  plic_pkg::src_id_t [`PLIC_CTX_NUM-1:0]  complete_id_i,
    output logic                                   pend_o
);

    localparam plic_pkg::src_id_t MY_ID = plic_pkg::src_id_t'(SRC_ID);

    plic_pkg::gw_state_t state_q;
    plic_pkg::gw_state_t state_nxt;

    logic src_lvl;
    logic src_lvl_d;
    logic src_edge;
    logic is_pend;
    logic claim_hit;
    logic cmplt_hit;

    // Two stage sampling, edge is taken from the registered copies.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            src_lvl   <= 1'b0;
            src_lvl_d <= 1'b0;
            src_edge  <= 1'b0;
        end else begin
            src_lvl   <= src_i;
            src_lvl_d <= src_lvl;
            src_edge  <= src_lvl & ~src_lvl_d;
        end
    end

    assign is_pend = type_i ? src_lvl : src_edge;

    always_comb begin
        claim_hit = 1'b0;
        cmplt_hit = 1'b0;
        for (int c = 0; c < `PLIC_CTX_NUM; c++) begin
            claim_hit = claim_hit | (claim_id_i[c] == MY_ID);
            cmplt_hit = cmplt_hit | (complete_id_i[c] == MY_ID);
        end
    end

    //////////////////////////////
    // Request FSM.
    //////////////////////////////
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            plic_pkg::GW_IDLE:  if (is_pend) state_nxt = plic_pkg::GW_PEND;
            plic_pkg::GW_PEND: begin
                if (claim_hit)            state_nxt = plic_pkg::GW_CLAIM;
                else if (type_i && !src_lvl) state_nxt = plic_pkg::GW_IDLE; // Level dropped.
            end
            plic_pkg::GW_CLAIM: if (cmplt_hit) state_nxt = plic_pkg::GW_IDLE;
            default:            state_nxt = plic_pkg::GW_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) state_q <= plic_pkg::GW_IDLE;
        else       state_q <= state_nxt;
    end

    assign pend_o = (state_q == plic_pkg::GW_PEND);

    a_state_legal: assert property (@(posedge clk) disable iff (!rstn)
        state_q inside {plic_pkg::GW_IDLE, plic_pkg::GW_PEND, plic_pkg::GW_CLAIM});

endmodule

// ==== hw/plic_pkg.sv ====
`include "plic_config.svh"

package plic_pkg;

    // Source number, 0 means none.
    typedef logic [$clog2(`PLIC_SRC_NUM)-1:0] src_id_t;

    typedef logic [`PLIC_PRIO_W-1:0] prio_t;

    // One bit per source slot.
    typedef logic [`PLIC_SRC_NUM-1:0] src_vec_t;

    //////////////////////////////
    // Gateway states.
    //////////////////////////////
    typedef enum logic [1:0] {
        GW_IDLE  = 2'b00,
        GW_PEND  = 2'b01,
        GW_CLAIM = 2'b10
    } gw_state_t;

endpackage

// ==== hw/plic_regs.sv ====
`include "plic_config.svh"

module plic_regs (
    input  logic                                       clk,
    input  logic                                       rstn,
    input  logic                                       reg_wr_i,
    input  logic                                       reg_rd_i,
    input  logic [`PLIC_ADDR_W-1:0]                    reg_addr_i,
    input  logic [`PLIC_DATA_W-1:0]                    reg_wdata_i,
    output logic [`PLIC_DATA_W-1:0]                    reg_rdata_o,
    input  plic_pkg::src_vec_t                         pend_i,
    input  plic_pkg::src_id_t  [`PLIC_CTX_NUM-1:0]     best_id_i,
    output plic_pkg::src_vec_t                         src_type_o,
    output plic_pkg::prio_t    [`PLIC_SRC_NUM-1:0]     prio_o,
    output plic_pkg::src_vec_t [`PLIC_CTX_NUM-1:0]     en_o,
    output plic_pkg::prio_t    [`PLIC_CTX_NUM-1:0]     th_o,
    output logic               [`PLIC_CTX_NUM-1:0]     claim_rd_o,
    output logic               [`PLIC_CTX_NUM-1:0]     complete_wr_o
);

    plic_pkg::prio_t    [`PLIC_SRC_NUM-1:0] prio_q;
    plic_pkg::src_vec_t                     type_q;
    plic_pkg::src_vec_t [`PLIC_CTX_NUM-1:0] en_q;
    plic_pkg::prio_t    [`PLIC_CTX_NUM-1:0] th_q;

    logic [`PLIC_SRC_NUM-1:0] prio_hit;
    logic [`PLIC_CTX_NUM-1:0] en_hit;
    logic [`PLIC_CTX_NUM-1:0] th_hit;
    logic [`PLIC_CTX_NUM-1:0] claim_hit;
    logic                     pend_hit;
    logic                     type_hit;
    logic [`PLIC_DATA_W-1:0]  rdata_nxt;

    function automatic logic [`PLIC_ADDR_W-1:0] reg_ofs(input int base, input int idx,
                                                       input int stride);
        return `PLIC_ADDR_W'(base + idx * stride);
    endfunction

    //////////////////////////////
    // Address decode.
    //////////////////////////////
    always_comb begin
        pend_hit = (reg_addr_i == `PLIC_OFS_PEND);
        type_hit = (reg_addr_i == `PLIC_OFS_TYPE);
        for (int s = 0; s < `PLIC_SRC_NUM; s++) begin
            prio_hit[s] = (reg_addr_i == reg_ofs(`PLIC_OFS_PRIO, s, 4));
        end
        for (int c = 0; c < `PLIC_CTX_NUM; c++) begin
            en_hit[c]    = (reg_addr_i == reg_ofs(`PLIC_OFS_EN, c, 4));
            th_hit[c]    = (reg_addr_i == reg_ofs(`PLIC_OFS_TH, c, 8));
            claim_hit[c] = (reg_addr_i == reg_ofs(`PLIC_OFS_CLAIM, c, 8));
        end
    end

    assign claim_rd_o    = claim_hit & {`PLIC_CTX_NUM{reg_rd_i}};
    assign complete_wr_o = claim_hit & {`PLIC_CTX_NUM{reg_wr_i}};

    //////////////////////////////
    // Configuration registers.
    //////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prio_q <= '0;
            type_q <= '0;
            en_q   <= '0;
            th_q   <= '0;
        end else if (reg_wr_i) begin
            // Slot 0 is never written.
            for (int s = 1; s < `PLIC_SRC_NUM; s++) begin
                if (prio_hit[s]) prio_q[s] <= reg_wdata_i[`PLIC_PRIO_W-1:0];
            end
            if (type_hit) type_q <= reg_wdata_i[`PLIC_SRC_NUM-1:0] & ~plic_pkg::src_vec_t'(1);
            for (int c = 0; c < `PLIC_CTX_NUM; c++) begin
                if (en_hit[c]) en_q[c] <= reg_wdata_i[`PLIC_SRC_NUM-1:0] & ~plic_pkg::src_vec_t'(1);
                if (th_hit[c]) th_q[c] <= reg_wdata_i[`PLIC_PRIO_W-1:0];
            end
        end
    end

    assign src_type_o = type_q;
    assign prio_o     = prio_q;
    assign en_o       = en_q;
    assign th_o       = th_q;

    // Read mux, unmapped reads give 0.
    always_comb begin
        rdata_nxt = '0;
        if (pend_hit) rdata_nxt = `PLIC_DATA_W'(pend_i);
        if (type_hit) rdata_nxt = `PLIC_DATA_W'(type_q);
        for (int s = 0; s < `PLIC_SRC_NUM; s++) begin
            if (prio_hit[s]) rdata_nxt = `PLIC_DATA_W'(prio_q[s]);
        end
        for (int c = 0; c < `PLIC_CTX_NUM; c++) begin
            if (en_hit[c])    rdata_nxt = `PLIC_DATA_W'(en_q[c]);
            if (th_hit[c])    rdata_nxt = `PLIC_DATA_W'(th_q[c]);
            if (claim_hit[c]) rdata_nxt = `PLIC_DATA_W'(best_id_i[c]); // Claimed ID.
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            reg_rdata_o <= '0;
        end else begin
            reg_rdata_o <= reg_rd_i ? rdata_nxt : '0;
        end
    end

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rstn) !(reg_wr_i && reg_rd_i));

endmodule

// ==== hw/plic_target.sv ====
`include "plic_config.svh"

module plic_target (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  plic_pkg::src_vec_t                     pend_i,
    input  plic_pkg::src_vec_t                     en_i,
    input  plic_pkg::prio_t   [`PLIC_SRC_NUM-1:0]  prio_i,
    input  plic_pkg::prio_t                        th_i,
    input  logic                                   claim_rd_i,
    input  logic                                   complete_wr_i,
    output plic_pkg::src_id_t                      best_id_o,
    output plic_pkg::src_id_t                      claim_id_o,
    output plic_pkg::src_id_t                      complete_id_o,
    output logic                                   eip_o
);

    plic_pkg::src_vec_t cand;
    plic_pkg::prio_t    best_prio;
    plic_pkg::src_id_t  best_src;
    plic_pkg::src_id_t  sel_id;
    plic_pkg::src_id_t  best_id_q;
    plic_pkg::src_id_t  claim_q;   // Outstanding claim, 0 is none.
    logic               outstanding;
    logic               best_upd;

    assign cand = pend_i & en_i;

    //////////////////////////////
    // Source selection.
    //////////////////////////////
    // Ascending scan with strict compare keeps the lower ID on a tie.
    always_comb begin
        best_prio = '0;
        best_src  = '0;
        for (int s = 1; s < `PLIC_SRC_NUM; s++) begin
            if (cand[s] && (prio_i[s] > best_prio)) begin
                best_prio = prio_i[s];
                best_src  = plic_pkg::src_id_t'(s);
            end
        end
    end

    assign sel_id = (best_prio > th_i) ? best_src : '0;

    assign outstanding = (claim_q != '0);

    // Frozen from the claim read until the complete.
    assign best_upd = (!outstanding && !claim_rd_i) || complete_wr_i;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            best_id_q <= '0;
        end else if (best_upd) begin
            best_id_q <= sel_id;
        end
    end

    //////////////////////////////
    // Claim and complete.
    //////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            claim_q <= '0;
        end else if (complete_wr_i) begin
            claim_q <= '0;
        end else if (claim_rd_i && !outstanding) begin
            claim_q <= best_id_q;
        end
    end

    assign claim_id_o    = (claim_rd_i && !outstanding) ? best_id_q : '0;
    assign complete_id_o = complete_wr_i ? claim_q : '0;

    assign best_id_o = best_id_q;
    assign eip_o     = (best_id_q != '0) && !outstanding;

    a_complete_claimed: assert property (@(posedge clk) disable iff (!rstn)
        complete_wr_i |-> outstanding);

endmodule

// ==== hw/plic_top.sv ====
`include "plic_config.svh"

module plic_top (
    input  logic                       clk,
    input  logic                       rstn,
    input  plic_pkg::src_vec_t         src_i,
    input  logic                       reg_wr_i,
    input  logic                       reg_rd_i,
    input  logic [`PLIC_ADDR_W-1:0]    reg_addr_i,
    input  logic [`PLIC_DATA_W-1:0]    reg_wdata_i,
    output logic [`PLIC_DATA_W-1:0]    reg_rdata_o,
    output logic [`PLIC_CTX_NUM-1:0]   eip_o
);

    plic_pkg::src_vec_t                     pend;
    plic_pkg::src_vec_t                     src_type;
    plic_pkg::prio_t    [`PLIC_SRC_NUM-1:0] prio;
    plic_pkg::src_vec_t [`PLIC_CTX_NUM-1:0] en;
    plic_pkg::prio_t    [`PLIC_CTX_NUM-1:0] th;
    logic               [`PLIC_CTX_NUM-1:0] claim_rd;
    logic               [`PLIC_CTX_NUM-1:0] complete_wr;
    plic_pkg::src_id_t  [`PLIC_CTX_NUM-1:0] best_id;
    plic_pkg::src_id_t  [`PLIC_CTX_NUM-1:0] claim_id;
    plic_pkg::src_id_t  [`PLIC_CTX_NUM-1:0] complete_id;

    plic_regs u_regs (
        .clk           (clk),
        .rstn          (rstn),
        .reg_wr_i      (reg_wr_i),
        .reg_rd_i      (reg_rd_i),
        .reg_addr_i    (reg_addr_i),
        .reg_wdata_i   (reg_wdata_i),
        .reg_rdata_o   (reg_rdata_o),
        .pend_i        (pend),
        .best_id_i     (best_id),
        .src_type_o    (src_type),
        .prio_o        (prio),
        .en_o          (en),
        .th_o          (th),
        .claim_rd_o    (claim_rd),
        .complete_wr_o (complete_wr)
    );

    assign pend[0] = 1'b0; // Reserved source.

    for (genvar s = 1; s < `PLIC_SRC_NUM; s++) begin : g_gateway
        plic_gateway #(.SRC_ID(s)) u_gateway (
            .clk           (clk),
            .rstn          (rstn),
            .src_i         (src_i[s]),
            .type_i        (src_type[s]),
            .claim_id_i    (claim_id),
            .complete_id_i (complete_id),
            .pend_o        (pend[s])
        );
    end

    for (genvar c = 0; c < `PLIC_CTX_NUM; c++) begin : g_target
        plic_target u_target (
            .clk           (clk),
            .rstn          (rstn),
            .pend_i        (pend),
            .en_i          (en[c]),
            .prio_i        (prio),
            .th_i          (th[c]),
            .claim_rd_i    (claim_rd[c]),
            .complete_wr_i (complete_wr[c]),
            .best_id_o     (best_id[c]),
            .claim_id_o    (claim_id[c]),
            .complete_id_o (complete_id[c]),
            .eip_o         (eip_o[c])
        );
    end

endmodule

// ==== tb/tb_checker.sv ====
`include "plic_config.svh"

module tb_checker (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     reg_wr_i,
    input  logic                     reg_rd_i,
    input  logic [`PLIC_ADDR_W-1:0]  reg_addr_i,
    input  logic [`PLIC_DATA_W-1:0]  reg_wdata_i,
    input  logic [`PLIC_DATA_W-1:0]  reg_rdata_i,
    input  logic [`PLIC_SRC_NUM-1:0] active_i,    // Sources the stimulus holds as requesting.
    input  int                       test_num_i,
    input  logic                     test_done_i,
    input  int                       ext_err_i,
    output int                       err_cnt_o,
    output int                       chk_cnt_o
);

    logic [`PLIC_SRC_NUM-1:0][`PLIC_PRIO_W-1:0]  prio_sh;
    logic [`PLIC_SRC_NUM-1:0]                    type_sh;
    logic [`PLIC_CTX_NUM-1:0][`PLIC_SRC_NUM-1:0] en_sh;
    logic [`PLIC_CTX_NUM-1:0][`PLIC_PRIO_W-1:0]  th_sh;
    logic [`PLIC_DATA_W-1:0]                     exp_q;
    logic                                        cmp_q;
    int                                          err_base;
    int                                          chk_base;

    function automatic string test_name(input int n);
        case (n)
            0:       return "readback";
            1:       return "random_level";
            2:       return "threshold";
            3:       return "claim_complete";
            4:       return "edge_once";
            5:       return "two_contexts";
            default: return "unknown";
        endcase
    endfunction

    // Expected claim ID. Walks priority levels from the top down.
    function automatic plic_pkg::src_id_t ref_claim_id(
        input logic [`PLIC_SRC_NUM-1:0][`PLIC_PRIO_W-1:0] prio,
        input logic [`PLIC_SRC_NUM-1:0]                   en,
        input logic [`PLIC_PRIO_W-1:0]                    th,
        input logic [`PLIC_SRC_NUM-1:0]                   act
    );
        plic_pkg::src_id_t id;
        id = '0;
        for (int p = (1 << `PLIC_PRIO_W) - 1; p > int'(th); p--) begin
            if (id == '0) begin
                // Descending scan, so the lowest matching source is kept.
                for (int s = `PLIC_SRC_NUM - 1; s > 0; s--) begin
                    if (act[s] && en[s] && int'(prio[s]) == p) id = plic_pkg::src_id_t'(s);
                end
            end
        end
        return id;
    endfunction

    function automatic logic [`PLIC_DATA_W-1:0] exp_read(input logic [`PLIC_ADDR_W-1:0] addr);
        logic [`PLIC_DATA_W-1:0] d;
        d = '0;
        for (int s = 0; s < `PLIC_SRC_NUM; s++) begin
            if (addr == 12'(`PLIC_OFS_PRIO + 4 * s)) d = 32'(prio_sh[s]);
        end
        if (addr == `PLIC_OFS_PEND) d = 32'(active_i & 8'hFE); // Unclaimed requests.
        if (addr == `PLIC_OFS_TYPE) d = 32'(type_sh);
        for (int c = 0; c < `PLIC_CTX_NUM; c++) begin
            if (addr == 12'(`PLIC_OFS_EN + 4 * c)) d = 32'(en_sh[c]);
            if (addr == 12'(`PLIC_OFS_TH + 8 * c)) d = 32'(th_sh[c]);
            if (addr == 12'(`PLIC_OFS_CLAIM + 8 * c)) begin
                d = 32'(ref_claim_id(prio_sh, en_sh[c], th_sh[c], active_i));
            end
        end
        return d;
    endfunction

    //////////////////////////////
    // Bus monitor and shadow registers.
    //////////////////////////////
    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prio_sh <= '0;
            type_sh <= '0;
            en_sh   <= '0;
            th_sh   <= '0;
            exp_q   <= '0;
            cmp_q   <= 1'b0;
        end else begin
            cmp_q <= reg_rd_i;
            exp_q <= exp_read(reg_addr_i);
            if (reg_wr_i) begin
                for (int s = 1; s < `PLIC_SRC_NUM; s++) begin
                    if (reg_addr_i == 12'(`PLIC_OFS_PRIO + 4 * s)) begin
                        prio_sh[s] <= reg_wdata_i[`PLIC_PRIO_W-1:0];
                    end
                end
                if (reg_addr_i == `PLIC_OFS_TYPE) type_sh <= reg_wdata_i[7:0] & 8'hFE;
                for (int c = 0; c < `PLIC_CTX_NUM; c++) begin
                    if (reg_addr_i == 12'(`PLIC_OFS_EN + 4 * c)) begin
                        en_sh[c] <= reg_wdata_i[7:0] & 8'hFE;
                    end
                    if (reg_addr_i == 12'(`PLIC_OFS_TH + 8 * c)) begin
                        th_sh[c] <= reg_wdata_i[`PLIC_PRIO_W-1:0];
                    end
                end
            end
        end
    end

    // Read data is stable at the falling edge after the read.
    always @(negedge clk) begin
        if (cmp_q) begin
            chk_cnt_o++;
            if (reg_rdata_i !== exp_q) begin
                err_cnt_o++;
                $display("Error %s expected %0h actual %0h", test_name(test_num_i), exp_q,
                         reg_rdata_i);
            end
        end
    end

    always @(posedge clk) begin
        if (test_done_i) begin
            $display("test %0d %s: %0d checks, %0d errors", test_num_i, test_name(test_num_i),
                     chk_cnt_o - chk_base, err_cnt_o + ext_err_i - err_base);
            chk_base = chk_cnt_o;
            err_base = err_cnt_o + ext_err_i;
        end
    end

    initial begin
        err_cnt_o = 0;
        chk_cnt_o = 0;
        err_base  = 0;
        chk_base  = 0;
    end

endmodule

// ==== tb/tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Reset is released on a falling edge.
    initial begin
        rstn_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;
    end

endmodule

// ==== tb/tb_top.sv ====
`include "plic_config.svh"

module tb_top;

    localparam int N_TESTS     = 6;
    localparam int TEST_CYCLES = 400;
    localparam int CLK_PERIOD  = 20;
    localparam int EIP_WAIT    = 4;

    logic                     clk;
    logic                     rstn;
    logic [`PLIC_SRC_NUM-1:0] src;
    logic [`PLIC_SRC_NUM-1:0] active;
    logic                     reg_wr;
    logic                     reg_rd;
    logic [`PLIC_ADDR_W-1:0]  reg_addr;
    logic [`PLIC_DATA_W-1:0]  reg_wdata;
    logic [`PLIC_DATA_W-1:0]  reg_rdata;
    logic [`PLIC_CTX_NUM-1:0] eip;
    logic                     test_done;
    int                       test_num;
    int                       tb_errs;
    int                       chk_errs;
    int                       chk_cnt;
    integer                   seed;

    tb_clk_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(4)) u_clk_gen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    plic_top DUT (
        .clk         (clk),
        .rstn        (rstn),
        .src_i       (src),
        .reg_wr_i    (reg_wr),
        .reg_rd_i    (reg_rd),
        .reg_addr_i  (reg_addr),
        .reg_wdata_i (reg_wdata),
        .reg_rdata_o (reg_rdata),
        .eip_o       (eip)
    );

    tb_checker u_checker (
        .clk         (clk),
        .rstn        (rstn),
        .reg_wr_i    (reg_wr),
        .reg_rd_i    (reg_rd),
        .reg_addr_i  (reg_addr),
        .reg_wdata_i (reg_wdata),
        .reg_rdata_i (reg_rdata),
        .active_i    (active),
        .test_num_i  (test_num),
        .test_done_i (test_done),
        .ext_err_i   (tb_errs),
        .err_cnt_o   (chk_errs),
        .chk_cnt_o   (chk_cnt)
    );

    function automatic logic [`PLIC_ADDR_W-1:0] addr_of(input logic [`PLIC_ADDR_W-1:0] base,
                                                        input int idx, input int stride);
        return `PLIC_ADDR_W'(base + idx * stride);
    endfunction

    //////////////////////////////
    // Bus and interrupt tasks.
    //////////////////////////////
    task automatic bus_write(input logic [`PLIC_ADDR_W-1:0] addr,
                             input logic [`PLIC_DATA_W-1:0] data);
        @(negedge clk);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    task automatic bus_read(input logic [`PLIC_ADDR_W-1:0] addr,
                            output logic [`PLIC_DATA_W-1:0] data);
        @(negedge clk);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge clk);
        reg_rd = 1'b0;
        data   = reg_rdata;
    endtask

    task automatic claim_ctx(input int c, output plic_pkg::src_id_t id);
        logic [`PLIC_DATA_W-1:0] d;
        bus_read(addr_of(`PLIC_OFS_CLAIM, c, 8), d);
        id = d[2:0];
    endtask

    // A complete is only sent for a real claim.
    task automatic complete_ctx(input int c, input plic_pkg::src_id_t id);
        if (id != '0) bus_write(addr_of(`PLIC_OFS_CLAIM, c, 8), 32'(id));
    endtask

    task automatic wait_eip(input int c);
        int n;
        n = 0;
        while (!eip[c] && n < EIP_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (!eip[c]) begin
            tb_errs++;
            $display("eip_o of context %0d did not rise within %0d cycles in test %0d",
                     c, EIP_WAIT, test_num);
        end
    endtask

    task automatic expect_eip_low(input int c, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (eip[c]) begin
                tb_errs++;
                $display("eip_o of context %0d was high in test %0d with nothing to serve",
                         c, test_num);
            end
        end
    endtask

    task automatic finish_test();
        @(negedge clk);
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
        test_num++;
    endtask

    //////////////////////////////
    // Tests.
    //////////////////////////////
    initial begin
        plic_pkg::src_id_t       id;
        plic_pkg::src_id_t       id1;
        logic [`PLIC_DATA_W-1:0] rd;
        seed      = 98074;
        src       = '0;
        active    = '0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        test_done = 1'b0;
        test_num  = 0;
        tb_errs   = 0;
        wait (rstn == 1'b1);

        // Register write and readback, source 0 and unmapped reads.
        for (int s = 0; s < `PLIC_SRC_NUM; s++) begin
            bus_write(addr_of(`PLIC_OFS_PRIO, s, 4), 32'(s + 3));
        end
        bus_write(`PLIC_OFS_TYPE, 32'hFF);
        bus_write(addr_of(`PLIC_OFS_EN, 0, 4), 32'h1A5);
        bus_write(addr_of(`PLIC_OFS_EN, 1, 4), 32'h15B);
        bus_write(addr_of(`PLIC_OFS_TH, 0, 8), 32'h0B);
        bus_write(addr_of(`PLIC_OFS_TH, 1, 8), 32'h06);
        for (int s = 0; s < `PLIC_SRC_NUM; s++) begin
            bus_read(addr_of(`PLIC_OFS_PRIO, s, 4), rd);
        end
        bus_read(`PLIC_OFS_TYPE, rd);
        for (int c = 0; c < `PLIC_CTX_NUM; c++) begin
            bus_read(addr_of(`PLIC_OFS_EN, c, 4), rd);
            bus_read(addr_of(`PLIC_OFS_TH, c, 8), rd);
        end
        bus_read(12'h088, rd);
        bus_read(12'h108, rd); // Enable slot of a missing context.
        bus_read(12'h300, rd);
        finish_test();

        // Random level sources, served one by one.
        bus_write(`PLIC_OFS_TYPE, 32'hFE);
        bus_write(addr_of(`PLIC_OFS_EN, 0, 4), 32'hFE);
        bus_write(addr_of(`PLIC_OFS_EN, 1, 4), 32'h00);
        bus_write(addr_of(`PLIC_OFS_TH, 0, 8), 32'h00);
        for (int s = 1; s < `PLIC_SRC_NUM; s++) begin
            bus_write(addr_of(`PLIC_OFS_PRIO, s, 4), 32'({$random(seed)} % 7 + 1));
        end
        src    = (8'($random(seed)) | 8'h02) & 8'hFE;
        active = src;
        for (int k = 0; k < 7 && active != '0; k++) begin
            wait_eip(0);
            claim_ctx(0, id);
            if (id == '0) break;
            src[id]    = 1'b0;
            active[id] = 1'b0;
            complete_ctx(0, id);
        end
        expect_eip_low(0, 4);
        finish_test();

        // Priority equal to and below the threshold.
        bus_write(addr_of(`PLIC_OFS_PRIO, 3, 4), 32'h2);
        bus_write(addr_of(`PLIC_OFS_PRIO, 4, 4), 32'h1);
        bus_write(addr_of(`PLIC_OFS_TH, 0, 8), 32'h2);
        src[3]    = 1'b1;
        src[4]    = 1'b1;
        active    = src;
        expect_eip_low(0, 6);
        bus_read(`PLIC_OFS_PEND, rd); // Both requests pend without being served.
        claim_ctx(0, id);
        src    = '0;
        active = '0;
        repeat (3) @(negedge clk);
        finish_test();

        // Claim, complete with level high, then complete after release.
        bus_write(addr_of(`PLIC_OFS_TH, 0, 8), 32'h0);
        src[5]    = 1'b1;
        active[5] = 1'b1;
        wait_eip(0);
        claim_ctx(0, id);
        if (eip[0]) begin
            tb_errs++;
            $display("eip_o of context 0 stayed high after a claim in test %0d", test_num);
        end
        complete_ctx(0, id);
        wait_eip(0);
        claim_ctx(0, id);
        src[5]    = 1'b0;
        active[5] = 1'b0;
        repeat (2) @(negedge clk);
        complete_ctx(0, id);
        expect_eip_low(0, 6);
        finish_test();

        // Single edge pulse on source 6.
        bus_write(`PLIC_OFS_TYPE, 32'hBE);
        src[6]    = 1'b1;
        active[6] = 1'b1;
        @(negedge clk);
        src[6] = 1'b0;
        wait_eip(0);
        claim_ctx(0, id);
        active[6] = 1'b0;
        complete_ctx(0, id);
        expect_eip_low(0, 8);
        claim_ctx(0, id);
        finish_test();

        // Two contexts with disjoint enables.
        bus_write(addr_of(`PLIC_OFS_EN, 0, 4), 32'h0E);
        bus_write(addr_of(`PLIC_OFS_EN, 1, 4), 32'h70);
        bus_write(addr_of(`PLIC_OFS_TH, 1, 8), 32'h0);
        src    = 8'h36;
        active = src;
        wait_eip(0);
        wait_eip(1);
        claim_ctx(0, id);
        claim_ctx(1, id1);
        src    = '0;
        active = '0;
        repeat (2) @(negedge clk);
        complete_ctx(0, id);
        complete_ctx(1, id1);
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", N_TESTS, chk_cnt, chk_errs + tb_errs);
        if (chk_errs + tb_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        #(N_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the tests did not finish",
                 N_TESTS * TEST_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
